/* design/iotrig_pkg.sv */
package iotrig_pkg;

	// Widths with a meaning of their own
	typedef logic [7:0] byte_t;        // One decoded serial byte
	typedef logic [63:0] pattern_t;    // Byte 0 in bits 7:0 is the newest
	typedef logic [7:0] mask_t;        // Clear bit means byte always matches
	typedef logic [15:0] baud_t;       // UART bit period in clk cycles
	typedef logic [7:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [1:0] axi_resp_t;
	typedef logic [15:0] trig_count_t;

	typedef enum logic {
		src_uart = 1'b0,
		src_spi  = 1'b1
	} src_sel_t;

	// UART receiver FSM
	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

	// Register map
	localparam axi_addr_t reg_ctrl_addr   = 8'h00; // Bit 0 enable, bit 1 source
	localparam axi_addr_t reg_baud_addr   = 8'h04;
	localparam axi_addr_t reg_mask_addr   = 8'h08;
	localparam axi_addr_t reg_pat_lo_addr = 8'h0C; // Pattern bytes 0 to 3
	localparam axi_addr_t reg_pat_hi_addr = 8'h10; // Pattern bytes 4 to 7
	localparam axi_addr_t reg_count_addr  = 8'h14; // Read only

	localparam axi_resp_t axi_resp_okay = 2'b00;

	localparam int trig_stretch = 128;     // Trigger hold after match ends
	localparam int trig_stretch_w = $clog2(trig_stretch + 1);
	localparam baud_t baud_reset = 16'd16;

endpackage

/* design/iotrig_regs.sv */
`timescale 1ns/10ps

module iotrig_regs (
	input logic clk,
	input logic reset,
	// Write address and data
	input logic awvalid,
	output logic awready,
	input iotrig_pkg::axi_addr_t awaddr,
	input logic wvalid,
	output logic wready,
	input iotrig_pkg::axi_data_t wdata,
	// Write response
	output logic bvalid,
	input logic bready,
	output iotrig_pkg::axi_resp_t bresp,
	// Read channels
	input logic arvalid,
	output logic arready,
	input iotrig_pkg::axi_addr_t araddr,
	output logic rvalid,
	input logic rready,
	output iotrig_pkg::axi_data_t rdata,
	output iotrig_pkg::axi_resp_t rresp,
	// Configuration out
	output logic enable,
	output iotrig_pkg::src_sel_t src_sel,
	output iotrig_pkg::baud_t baud_period,
	output iotrig_pkg::mask_t mask,
	output iotrig_pkg::pattern_t pattern,
	input iotrig_pkg::trig_count_t trig_count
);
	import iotrig_pkg::*;

	logic wr_accept;     // Shared ready for address and data
	logic wr_fire;
	logic rd_fire;
	axi_data_t rd_word;

	assign awready = wr_accept;
	assign wready = wr_accept;
	assign wr_fire = wr_accept & awvalid & wvalid;
	assign rd_fire = arready & arvalid;

	// Every access answers OKAY
	assign bresp = axi_resp_okay;
	assign rresp = axi_resp_okay;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_accept <= 1'b0;
			bvalid <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			// Accept only with both address and data present, one at a time
			wr_accept <= awvalid & wvalid & ~wr_accept & ~bvalid;
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;      // Response taken
			arready <= arvalid & ~arready & ~rvalid;
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// Configuration registers
	always_ff @(posedge clk) begin
		if (reset) begin
			enable <= 1'b0;
			src_sel <= src_uart;
			baud_period <= baud_reset;
			mask <= '0;
			pattern <= '0;
		end else if (wr_fire) begin
			case (awaddr)
				reg_ctrl_addr: begin
					enable <= wdata[0];
					src_sel <= src_sel_t'(wdata[1]);
				end
				reg_baud_addr: baud_period <= wdata[15:0];
				reg_mask_addr: mask <= wdata[7:0];
				reg_pat_lo_addr: pattern[31:0] <= wdata;   // Bytes 0 to 3
				reg_pat_hi_addr: pattern[63:32] <= wdata;  // Bytes 4 to 7
				default: ;                                 // Unknown address ignored
			endcase
		end
	end

	// Read mux
	always_comb begin
		case (araddr)
			reg_ctrl_addr: rd_word = {30'd0, src_sel, enable};
			reg_baud_addr: rd_word = {16'd0, baud_period};
			reg_mask_addr: rd_word = {24'd0, mask};
			reg_pat_lo_addr: rd_word = pattern[31:0];
			reg_pat_hi_addr: rd_word = pattern[63:32];
			reg_count_addr: rd_word = {16'd0, trig_count};
			default: rd_word = '0;
		endcase
	end

	// Read data captured with the address handshake
	always_ff @(posedge clk) begin
		if (rd_fire)
			rdata <= rd_word;
	end

endmodule

/* design/uart_byte_rx.sv */
`timescale 1ns/10ps

module uart_byte_rx (
	input logic clk,
	input logic reset,
	input logic rxd,
	input iotrig_pkg::baud_t baud_period,
	output iotrig_pkg::byte_t data,
	output logic valid
);
	import iotrig_pkg::*;

	logic rxd_meta;
	logic rxd_sync;
	logic rxd_prev;       // For falling edge detect
	rx_state_t state;
	baud_t period_cnt;    // Counts down to the next sample point
	logic [2:0] bit_idx;
	byte_t shift;
	logic sample_bit;
	logic stop_ok;

	assign sample_bit = (state == rx_data) && (period_cnt == '0);
	assign stop_ok = (state == rx_stop) && (period_cnt == '0) && rxd_sync;

	// Two-stage synchronizer, line idles high
	always_ff @(posedge clk) begin
		if (reset) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= rx_idle;
			period_cnt <= '0;
			bit_idx <= '0;
			valid <= 1'b0;
		end else begin
			valid <= stop_ok;   // Strobe at mid stop bit
			case (state)
				rx_idle: begin
					if (rxd_prev && !rxd_sync) begin
						period_cnt <= baud_period >> 1;   // Half period to mid start bit
						state <= rx_start;
					end
				end
				rx_start: begin
					if (period_cnt != '0)
						period_cnt <= period_cnt - 1'b1;
					else if (!rxd_sync) begin
						period_cnt <= baud_period - 1'b1;
						bit_idx <= '0;
						state <= rx_data;
					end else
						state <= rx_idle;   // Glitch, not a start bit
				end
				rx_data: begin
					if (period_cnt != '0)
						period_cnt <= period_cnt - 1'b1;
					else begin
						period_cnt <= baud_period - 1'b1;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= rx_stop;
					end
				end
				rx_stop: begin
					if (period_cnt != '0)
						period_cnt <= period_cnt - 1'b1;
					else
						state <= rx_idle;   // Bad stop bit just drops the byte
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge clk) begin
		if (sample_bit)
			shift <= {rxd_sync, shift[7:1]};
		if (stop_ok)
			data <= shift;
	end

endmodule

/* design/spi_byte_rx.sv */
`timescale 1ns/10ps

module spi_byte_rx (
	input logic clk,
	input logic reset,
	input logic sck,
	input logic mosi,
	input logic cs_n,
	output iotrig_pkg::byte_t data,
	output logic valid
);
	import iotrig_pkg::*;

	logic sck_meta, sck_sync, sck_prev;
	logic mosi_meta, mosi_sync;
	logic cs_meta, cs_sync;
	logic [2:0] bit_cnt;
	byte_t shift;
	logic take_bit;

	// Mode 0 samples on rising sck while selected
	assign take_bit = sck_sync & ~sck_prev & ~cs_sync;

	always_ff @(posedge clk) begin
		if (reset) begin
			sck_meta <= 1'b0;
			sck_sync <= 1'b0;
			sck_prev <= 1'b0;
			mosi_meta <= 1'b0;
			mosi_sync <= 1'b0;
			cs_meta <= 1'b1;   // Deselected
			cs_sync <= 1'b1;
		end else begin
			sck_meta <= sck;
			sck_sync <= sck_meta;
			sck_prev <= sck_sync;
			mosi_meta <= mosi;     // Same delay as sck keeps data aligned
			mosi_sync <= mosi_meta;
			cs_meta <= cs_n;
			cs_sync <= cs_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt <= '0;
			valid <= 1'b0;
		end else begin
			valid <= take_bit && (bit_cnt == 3'd7);
			if (cs_sync)
				bit_cnt <= '0;     // Partial byte discarded
			else if (take_bit)
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// MSB first
	always_ff @(posedge clk) begin
		if (take_bit)
			shift <= {shift[6:0], mosi_sync};
		if (take_bit && (bit_cnt == 3'd7))
			data <= {shift[6:0], mosi_sync};
	end

endmodule

/* design/byte_window.sv */
`timescale 1ns/10ps

module byte_window (
	input logic clk,
	input logic reset,
	input iotrig_pkg::src_sel_t src_sel,
	input iotrig_pkg::byte_t uart_data,
	input logic uart_valid,
	input iotrig_pkg::byte_t spi_data,
	input logic spi_valid,
	output iotrig_pkg::pattern_t window,
	output logic window_upd
);
	import iotrig_pkg::*;

	byte_t sel_data;
	logic sel_valid;

	// Unselected source is simply not looked at
	always_comb begin
		case (src_sel)
			src_spi: begin
				sel_data = spi_data;
				sel_valid = spi_valid;
			end
			default: begin
				sel_data = uart_data;
				sel_valid = uart_valid;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			window <= '0;
			window_upd <= 1'b0;
		end else begin
			window_upd <= sel_valid;   // High while the new window is first visible
			if (sel_valid)
				window <= {window[55:0], sel_data};   // Byte 7 falls off the end
		end
	end

endmodule

/* design/pattern_trigger.sv */
`timescale 1ns/10ps

module pattern_trigger (
	input logic clk,
	input logic reset,
	input logic enable,
	input iotrig_pkg::pattern_t window,
	input logic window_upd,
	input iotrig_pkg::mask_t mask,
	input iotrig_pkg::pattern_t pattern,
	output logic trig,
	output iotrig_pkg::trig_count_t trig_count
);
	import iotrig_pkg::*;

	mask_t byte_hit;      // Per byte compare, masked bytes always hit
	logic match_q;        // Registered full match
	logic match_d;        // Previous match, cleared on a new byte
	logic confirmed;
	logic confirm_next;
	logic trig_q;
	logic [trig_stretch_w-1:0] stretch_cnt;

	always_comb begin
		for (int i = 0; i < 8; i++)
			byte_hit[i] = (window[i*8 +: 8] == pattern[i*8 +: 8]) | ~mask[i];
	end

	// Needs two flag cycles to start, then holds while the flag stays up
	assign confirm_next = enable & match_q & (match_d | confirmed);

	always_ff @(posedge clk) begin
		if (reset) begin
			match_q <= 1'b0;
			match_d <= 1'b0;
			confirmed <= 1'b0;
			trig_q <= 1'b0;
			stretch_cnt <= '0;
			trig_count <= '0;
		end else begin
			match_q <= enable & (&byte_hit);
			match_d <= window_upd ? 1'b0 : match_q;   // Restart qualification
			confirmed <= confirm_next;
			if (!enable) begin
				trig_q <= 1'b0;
				stretch_cnt <= '0;
			end else begin
				trig_q <= confirm_next | (stretch_cnt != '0);
				if (confirm_next)
					stretch_cnt <= trig_stretch_w'(trig_stretch);   // Reload while matching
				else if (stretch_cnt != '0)
					stretch_cnt <= stretch_cnt - 1'b1;
			end
			// One count per confirmed match rising edge
			if (confirm_next && !confirmed)
				trig_count <= trig_count + 1'b1;
		end
	end

	// Disable kills the output at once
	assign trig = trig_q & enable;

endmodule

/* design/iotrig_top.sv */
`timescale 1ns/10ps

module iotrig_top (
	input logic clk,
	input logic reset,
	input logic awvalid,
	output logic awready,
	input iotrig_pkg::axi_addr_t awaddr,
	input logic wvalid,
	output logic wready,
	input iotrig_pkg::axi_data_t wdata,
	output logic bvalid,
	input logic bready,
	output iotrig_pkg::axi_resp_t bresp,
	input logic arvalid,
	output logic arready,
	input iotrig_pkg::axi_addr_t araddr,
	output logic rvalid,
	input logic rready,
	output iotrig_pkg::axi_data_t rdata,
	output iotrig_pkg::axi_resp_t rresp,
	input logic uart_rxd,      // Async serial inputs
	input logic spi_sck,
	input logic spi_mosi,
	input logic spi_cs_n,
	output logic trig
);
	import iotrig_pkg::*;

	logic enable;
	src_sel_t src_sel;
	baud_t baud_period;
	mask_t mask;
	pattern_t pattern;
	trig_count_t trig_count;
	byte_t uart_data, spi_data;
	logic uart_valid, spi_valid;
	pattern_t window;
	logic window_upd;

	iotrig_regs u_regs (
		.clk(clk), .reset(reset),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.enable(enable), .src_sel(src_sel), .baud_period(baud_period),
		.mask(mask), .pattern(pattern), .trig_count(trig_count)
	);

	uart_byte_rx u_uart (
		.clk(clk), .reset(reset), .rxd(uart_rxd), .baud_period(baud_period),
		.data(uart_data), .valid(uart_valid)
	);

	spi_byte_rx u_spi (
		.clk(clk), .reset(reset), .sck(spi_sck), .mosi(spi_mosi), .cs_n(spi_cs_n),
		.data(spi_data), .valid(spi_valid)
	);

	// Both receivers run, the window picks one
	byte_window u_window (
		.clk(clk), .reset(reset), .src_sel(src_sel),
		.uart_data(uart_data), .uart_valid(uart_valid),
		.spi_data(spi_data), .spi_valid(spi_valid),
		.window(window), .window_upd(window_upd)
	);

	pattern_trigger u_trigger (
		.clk(clk), .reset(reset), .enable(enable), .window(window),
		.window_upd(window_upd), .mask(mask), .pattern(pattern),
		.trig(trig), .trig_count(trig_count)
	);

endmodule

/* sim/iotrig_properties.sv */
`timescale 1ns/10ps

module iotrig_properties (
	input logic clk,
	input logic reset,
	input logic awvalid,
	input logic awready,
	input iotrig_pkg::axi_addr_t awaddr,
	input logic wvalid,
	input logic wready,
	input iotrig_pkg::axi_data_t wdata,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic trig
);
	import iotrig_pkg::*;

	logic bus_enable;       // Enable bit as last written over AXI
	logic [8:0] high_len;   // Consecutive cycles with trig high, saturating

	always_ff @(posedge clk) begin
		if (reset)
			bus_enable <= 1'b0;
		else if (awvalid && awready && wvalid && wready && awaddr == reg_ctrl_addr)
			bus_enable <= wdata[0];
	end

	always_ff @(posedge clk) begin
		if (reset || !trig)
			high_len <= '0;
		else if (high_len != 9'h1ff)
			high_len <= high_len + 1'b1;
	end

	// Responses held until taken
	bvalid_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");

	rvalid_hold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

	trig_off_when_disabled: assert property (@(posedge clk) disable iff (reset)
		!bus_enable |-> !trig) else $error("trig high while disabled");

	// Stretch length, unless disable cut it short
	trig_min_width: assert property (@(posedge clk) disable iff (reset)
		$fell(trig) && bus_enable |-> int'(high_len) >= trig_stretch)
		else $error("trig pulse shorter than the stretch");

endmodule

bind iotrig_top iotrig_properties u_props (
	.clk(clk), .reset(reset),
	.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
	.wvalid(wvalid), .wready(wready), .wdata(wdata),
	.bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready),
	.trig(trig)
);

/* sim/tb_iotrig.sv */
`timescale 1ns/10ps

module tb_iotrig;
	import iotrig_pkg::*;

	localparam int max_baud = 40;
	localparam int max_bytes = 140;                    // Upper bound of bytes sent
	localparam int byte_cycles = 10 * max_baud + 200;  // Frame plus check slack
	localparam int watchdog_ns = 2 * max_bytes * byte_cycles * 8 + 20000;

	logic clk, reset;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	axi_addr_t awaddr, araddr;
	axi_data_t wdata, rdata;
	axi_resp_t bresp, rresp;
	logic uart_rxd, spi_sck, spi_mosi, spi_cs_n;
	logic trig;

	byte_t win[$];          // Model window, index 0 newest
	logic m_en;
	src_sel_t m_src;
	baud_t m_baud;
	mask_t m_mask;
	pattern_t m_pat;
	logic m_prev;           // Model match on the previous update
	logic recent;           // Stretch may still hold trig
	int m_count;
	axi_data_t rd;

	iotrig_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		#(watchdog_ns);
		$display("timeout: the run did not finish within %0d ns", watchdog_ns);
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "check failed");
		end
	endtask

	function automatic byte_t rand_byte();
		return byte_t'($urandom());
	endfunction

	task automatic axi_write(input axi_addr_t addr, input axi_data_t data);
		int stall;
		stall = int'($urandom() % 4);   // Cycles of response back-pressure
		@(posedge clk);
		#1;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(negedge clk);
		while (!(awready && wready)) @(negedge clk);
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(negedge clk);
		while (!bvalid) @(negedge clk);
		check_value(64'(bresp), 64'd0, "bresp OKAY");
		repeat (stall) @(posedge clk);
		@(posedge clk);
		#1;
		bready = 1'b1;
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
		int stall;
		stall = int'($urandom() % 4);   // Cycles of response back-pressure
		@(posedge clk);
		#1;
		araddr = addr;
		arvalid = 1'b1;
		@(negedge clk);
		while (!arready) @(negedge clk);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		@(negedge clk);
		while (!rvalid) @(negedge clk);
		data = rdata;
		check_value(64'(rresp), 64'd0, "rresp OKAY");
		repeat (stall) @(posedge clk);
		@(posedge clk);
		#1;
		rready = 1'b1;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic uart_frame(input byte_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};   // Stop, data LSB first, start
		@(posedge clk);
		#1;
		for (int i = 0; i < 10; i++) begin
			uart_rxd = frame[i];
			repeat (m_baud) @(posedge clk);
			#1;
		end
	endtask

	task automatic spi_byte(input byte_t b);
		@(posedge clk);
		#1;
		spi_cs_n = 1'b0;
		for (int i = 7; i >= 0; i--) begin
			spi_mosi = b[i];            // MSB first, set up before rising sck
			repeat (4) @(posedge clk);
			#1;
			spi_sck = 1'b1;
			repeat (4) @(posedge clk);
			#1;
			spi_sck = 1'b0;
		end
		spi_cs_n = 1'b1;
	endtask

	function automatic logic model_match();
		for (int i = 0; i < 8; i++)
			if (m_mask[i] && win[i] != m_pat[i*8 +: 8])
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic update_model();
		logic cur;
		cur = m_en && model_match();
		if (cur && !m_prev)
			m_count++;               // Rising edge of a confirmed match
		m_prev = cur;
	endtask

	task automatic push_model(input byte_t b);
		win.push_front(b);
		void'(win.pop_back());
		update_model();
	endtask

	// Send on the selected source, then check trig 40 cycles after the frame
	task automatic send_byte(input byte_t b);
		if (m_src == src_spi) begin
			fork
				spi_byte(b);
				uart_frame(rand_byte());   // Noise on the unselected line
			join
		end else
			uart_frame(b);
		push_model(b);
		repeat (40) @(posedge clk);
		@(negedge clk);
		if (m_prev)
			check_value(64'(trig), 64'd1, "trig on matching window");
		else if (!recent)
			check_value(64'(trig), 64'd0, "trig on non-matching window");
		recent = m_prev;
	endtask

	// Config changed while disabled, so no half-written pattern can count
	task automatic set_config(input logic en, input src_sel_t src, input baud_t baud,
			input mask_t msk, input pattern_t pat);
		axi_write(reg_ctrl_addr, axi_data_t'({src, 1'b0}));
		m_en = 1'b0;
		update_model();
		axi_write(reg_baud_addr, axi_data_t'(baud));
		axi_write(reg_mask_addr, axi_data_t'(msk));
		axi_write(reg_pat_lo_addr, pat[31:0]);
		axi_write(reg_pat_hi_addr, pat[63:32]);
		axi_write(reg_ctrl_addr, axi_data_t'({src, en}));
		m_src = src;
		m_baud = baud;
		m_mask = msk;
		m_pat = pat;
		m_en = en;
		update_model();
		recent = m_prev;
	endtask

	task automatic run_sequence(input int n_rand);
		for (int i = 0; i < n_rand; i++)
			send_byte(rand_byte());
		for (int i = 7; i >= 0; i--)     // Oldest pattern byte first
			send_byte(m_mask[i] ? m_pat[i*8 +: 8] : rand_byte());
	endtask

	function automatic baud_t rand_baud();
		return baud_t'(16 + $urandom() % 25);
	endfunction

	function automatic pattern_t rand_pat();
		return {$urandom(), $urandom()};
	endfunction

	initial begin
		int n;
		baud_t b;
		mask_t mk;
		pattern_t p;
		reset = 1'b1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		arvalid = 1'b0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		bready = 1'b0;
		rready = 1'b0;
		uart_rxd = 1'b1;        // Idle line
		spi_sck = 1'b0;
		spi_mosi = 1'b0;
		spi_cs_n = 1'b1;
		void'($urandom(32'h9a17_927d));
		for (int i = 0; i < 8; i++)
			win.push_back(8'h00);
		m_en = 1'b0;
		m_src = src_uart;
		m_baud = baud_reset;
		m_mask = '0;
		m_pat = '0;
		m_prev = 1'b0;
		recent = 1'b0;
		m_count = 0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		// Reset values and readback
		axi_read(reg_ctrl_addr, rd);
		check_value(64'(rd), 64'd0, "ctrl after reset");
		axi_read(reg_baud_addr, rd);
		check_value(64'(rd), 64'(baud_reset), "baud after reset");
		axi_read(reg_mask_addr, rd);
		check_value(64'(rd), 64'd0, "mask after reset");
		axi_read(reg_pat_lo_addr, rd);
		check_value(64'(rd), 64'd0, "pattern lo after reset");
		axi_read(reg_pat_hi_addr, rd);
		check_value(64'(rd), 64'd0, "pattern hi after reset");
		axi_read(reg_count_addr, rd);
		check_value(64'(rd), 64'd0, "count after reset");
		b = rand_baud();
		mk = mask_t'($urandom());
		p = rand_pat();
		set_config(1'b0, src_uart, b, mk, p);
		axi_read(reg_baud_addr, rd);
		check_value(64'(rd), 64'(b), "baud readback");
		axi_read(reg_mask_addr, rd);
		check_value(64'(rd), 64'(mk), "mask readback");
		axi_read(reg_pat_lo_addr, rd);
		check_value(64'(rd), 64'(p[31:0]), "pattern lo readback");
		axi_read(reg_pat_hi_addr, rd);
		check_value(64'(rd), 64'(p[63:32]), "pattern hi readback");
		axi_write(8'h20, 32'hffff_ffff);
		axi_read(8'h20, rd);
		check_value(64'(rd), 64'd0, "unknown address");

		// UART then SPI matching
		for (int r = 0; r < 2; r++) begin
			set_config(1'b1, src_uart, rand_baud(), mask_t'($urandom()), rand_pat());
			run_sequence(6);
		end
		for (int r = 0; r < 2; r++) begin
			set_config(1'b1, src_spi, rand_baud(), mask_t'($urandom()), rand_pat());
			run_sequence(6);
		end

		// Mask zero matches at once
		set_config(1'b1, src_spi, rand_baud(), 8'h00, rand_pat());
		n = 0;
		@(negedge clk);
		while (!trig && n < 40) begin
			@(negedge clk);
			n++;
		end
		check_value(64'(trig), 64'd1, "trig with mask zero");

		// Stretch after the match ends
		p = rand_pat();
		set_config(1'b1, src_spi, rand_baud(), 8'h01, {p[63:8], 8'ha5});
		send_byte(8'ha5);
		spi_byte(8'h5a);
		push_model(8'h5a);
		n = 0;
		@(negedge clk);
		while (trig && n < trig_stretch + 40) begin
			@(negedge clk);
			n++;
		end
		check_value(64'(n >= trig_stretch && !trig), 64'd1, "trig stretch length");
		recent = 1'b0;

		// Mixed run for the counter
		for (int r = 0; r < 3; r++) begin
			set_config(1'b1, src_sel_t'($urandom() % 2), rand_baud(),
				mask_t'($urandom() & $urandom()), rand_pat());
			run_sequence(4 + int'($urandom() % 4));
		end
		axi_read(reg_count_addr, rd);
		check_value(64'(rd), 64'(m_count), "trigger count");

		// Disabled, nothing fires or counts
		set_config(1'b0, src_uart, rand_baud(), mask_t'($urandom()), rand_pat());
		run_sequence(2);
		axi_read(reg_count_addr, rd);
		check_value(64'(rd), 64'(m_count), "count while disabled");

		$display("TB PASSED");
		$finish;
	end

endmodule

/* verilog.f */
design/iotrig_pkg.sv
design/iotrig_regs.sv
design/uart_byte_rx.sv
design/spi_byte_rx.sv
design/byte_window.sv
design/pattern_trigger.sv
design/iotrig_top.sv
sim/iotrig_properties.sv
sim/tb_iotrig.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module tb_iotrig \
	-Mdir obj_dir -o tb_iotrig_sim
./obj_dir/tb_iotrig_sim > sim.log 2>&1
cat sim.log
if grep -q "^TB PASSED$" sim.log; then
	exit 0
else
	exit 1
fi
